/* src/io_pkg.sv */
// I/O subsystem shared definitions

package io_pkg;

	// ========================================
	// bus geometry
	// ========================================
	localparam int DATA_BITS = 16;
	localparam int ADDR_BITS = 8;
	// upper nibble picks the device, lower nibble the register
	localparam int DEV_BITS = 4;
	localparam int REG_BITS = 4;

	// device select codes
	localparam logic [DEV_BITS-1:0] DEV_IRQ   = 4'd0;
	localparam logic [DEV_BITS-1:0] DEV_VIDEO = 4'd1;
	localparam logic [DEV_BITS-1:0] DEV_AUDIO = 4'd2;
	localparam logic [DEV_BITS-1:0] DEV_SPI   = 4'd3;

	// ========================================
	// register offsets
	// ========================================
	localparam logic [REG_BITS-1:0] REG_IRQ_ENABLE    = 4'd0;
	localparam logic [REG_BITS-1:0] REG_IRQ_PENDING   = 4'd1;
	localparam logic [REG_BITS-1:0] REG_VIDEO_ENABLE  = 4'd0;
	localparam logic [REG_BITS-1:0] REG_AUDIO_DIVISOR = 4'd0;
	localparam logic [REG_BITS-1:0] REG_SPI_DATA      = 4'd0;
	localparam logic [REG_BITS-1:0] REG_SPI_STATUS    = 4'd1;

	// interrupt source bits, lowest index wins
	localparam int IRQ_HSYNC = 0;
	localparam int IRQ_VSYNC = 1;
	localparam int IRQ_AUDIO = 2;
	localparam int IRQ_SPI   = 3;
	localparam int NUM_IRQ   = 4;

endpackage

/* src/interrupt_controller.sv */
// Interrupt controller
// enable mask, sticky pending bits, priority request

module interrupt_controller (
	input  logic                           CLK,
	input  logic                           RSTb,
	input  logic [io_pkg::REG_BITS-1:0]    reg_addr,
	input  logic [io_pkg::DATA_BITS-1:0]   data_in,
	input  logic                           wr,
	input  logic                           irq_hsync,
	input  logic                           irq_vsync,
	input  logic                           irq_audio,
	input  logic                           irq_spi_flash,
	output logic [io_pkg::DATA_BITS-1:0]   data_out,
	output logic                           interrupt,
	output logic [3:0]                     irq
);

	logic [io_pkg::NUM_IRQ-1:0] irq_in;
	logic [io_pkg::NUM_IRQ-1:0] irq_pending;
	logic [io_pkg::NUM_IRQ-1:0] irq_pending_next;
	logic [io_pkg::NUM_IRQ-1:0] irq_clear;
	logic [io_pkg::NUM_IRQ-1:0] irq_clear_next;
	logic [io_pkg::NUM_IRQ-1:0] irq_enabled;
	logic [io_pkg::NUM_IRQ-1:0] irq_enabled_next;
	logic [io_pkg::NUM_IRQ-1:0] irq_active;
	logic [3:0]                 irq_next;

	// gather the event pulses into one vector
	always_comb begin
		irq_in = '0;
		irq_in[io_pkg::IRQ_HSYNC] = irq_hsync;
		irq_in[io_pkg::IRQ_VSYNC] = irq_vsync;
		irq_in[io_pkg::IRQ_AUDIO] = irq_audio;
		irq_in[io_pkg::IRQ_SPI]   = irq_spi_flash;
	end

	// ========================================
	// register port
	// ========================================
	always_comb begin
		irq_enabled_next = irq_enabled;
		irq_clear_next = '0;
		data_out = '0;
		case (reg_addr)
			io_pkg::REG_IRQ_ENABLE: begin
				if (wr) begin
					irq_enabled_next = data_in[io_pkg::NUM_IRQ-1:0];
				end
				data_out[io_pkg::NUM_IRQ-1:0] = irq_enabled;
			end
			io_pkg::REG_IRQ_PENDING: begin
				// write a one to clear, applied one edge later
				if (wr) begin
					irq_clear_next = data_in[io_pkg::NUM_IRQ-1:0];
				end
				data_out[io_pkg::NUM_IRQ-1:0] = irq_pending;
			end
			default: ;
		endcase
	end

	// a fresh pulse beats a clear in the same cycle
	assign irq_pending_next = (irq_pending & ~irq_clear) | irq_in;

	// ========================================
	// priority encoder
	// ========================================
	assign irq_active = irq_pending & irq_enabled;

	always_comb begin
		irq_next = 4'd0;
		// walk downwards so the lowest set bit is the one kept
		for (int i = io_pkg::NUM_IRQ - 1; i >= 0; i--) begin
			if (irq_active[i]) begin
				irq_next = 4'(i + 1);
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			irq_pending <= '0;
			irq_clear <= '0;
			irq_enabled <= '0;
			irq <= 4'd0;
			interrupt <= 1'b0;
		end else begin
			irq_pending <= irq_pending_next;
			irq_clear <= irq_clear_next;
			irq_enabled <= irq_enabled_next;
			irq <= irq_next;
			interrupt <= (irq_next != 4'd0);
		end
	end

endmodule

/* src/io_decoder.sv */
// Register bus address decoder

module io_decoder (
	input  logic [io_pkg::ADDR_BITS-1:0] address,
	input  logic                         wr,
	input  logic [io_pkg::DATA_BITS-1:0] rd_irq,
	input  logic [io_pkg::DATA_BITS-1:0] rd_video,
	input  logic [io_pkg::DATA_BITS-1:0] rd_audio,
	input  logic [io_pkg::DATA_BITS-1:0] rd_spi,
	output logic [io_pkg::REG_BITS-1:0]  reg_addr,
	output logic                         wr_irq,
	output logic                         wr_video,
	output logic                         wr_audio,
	output logic                         wr_spi,
	output logic [io_pkg::DATA_BITS-1:0] data_out
);

	logic [io_pkg::DEV_BITS-1:0] dev_sel;

	assign dev_sel  = address[io_pkg::ADDR_BITS-1 -: io_pkg::DEV_BITS];
	assign reg_addr = address[io_pkg::REG_BITS-1:0];

	// one strobe per device, only the selected one fires
	assign wr_irq   = wr && (dev_sel == io_pkg::DEV_IRQ);
	assign wr_video = wr && (dev_sel == io_pkg::DEV_VIDEO);
	assign wr_audio = wr && (dev_sel == io_pkg::DEV_AUDIO);
	assign wr_spi   = wr && (dev_sel == io_pkg::DEV_SPI);

	// read mux, unmapped devices give zero
	always_comb begin
		case (dev_sel)
			io_pkg::DEV_IRQ:   data_out = rd_irq;
			io_pkg::DEV_VIDEO: data_out = rd_video;
			io_pkg::DEV_AUDIO: data_out = rd_audio;
			io_pkg::DEV_SPI:   data_out = rd_spi;
			default:           data_out = '0;
		endcase
	end

endmodule

/* src/video_timing.sv */
// Video sync pulse generator

module video_timing #(
	parameter int H_TOTAL = 800,
	parameter int V_TOTAL = 525
) (
	input  logic                         CLK,
	input  logic                         RSTb,
	input  logic [io_pkg::REG_BITS-1:0]  reg_addr,
	input  logic [io_pkg::DATA_BITS-1:0] data_in,
	input  logic                         wr,
	output logic [io_pkg::DATA_BITS-1:0] data_out,
	output logic                         hsync,
	output logic                         vsync
);

	localparam int H_BITS = $clog2(H_TOTAL + 1);
	localparam int V_BITS = $clog2(V_TOTAL + 1);
	localparam logic [H_BITS-1:0] H_LAST = H_BITS'(H_TOTAL - 1);
	localparam logic [V_BITS-1:0] V_LAST = V_BITS'(V_TOTAL - 1);

	logic              enable;
	logic [H_BITS-1:0] h_count;
	logic [V_BITS-1:0] v_count;
	logic              line_end;
	logic              frame_end;

	assign line_end  = (h_count == H_LAST);
	assign frame_end = line_end && (v_count == V_LAST);

	// enable register
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			enable <= 1'b0;
		end else if (wr && reg_addr == io_pkg::REG_VIDEO_ENABLE) begin
			enable <= data_in[0];
		end
	end

	always_comb begin
		data_out = '0;
		if (reg_addr == io_pkg::REG_VIDEO_ENABLE) begin
			data_out[0] = enable;
		end
	end

	// ========================================
	// line and frame counters
	// ========================================
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			h_count <= '0;
			v_count <= '0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else if (!enable) begin
			// parked at the top left while off
			h_count <= '0;
			v_count <= '0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			hsync <= line_end;
			vsync <= frame_end;
			if (line_end) begin
				h_count <= '0;
				if (frame_end) begin
					v_count <= '0;
				end else begin
					v_count <= v_count + 1'b1;
				end
			end else begin
				h_count <= h_count + 1'b1;
			end
		end
	end

endmodule

/* src/audio_sample_timer.sv */
// Audio sample rate timer

module audio_sample_timer (
	input  logic                         CLK,
	input  logic                         RSTb,
	input  logic [io_pkg::REG_BITS-1:0]  reg_addr,
	input  logic [io_pkg::DATA_BITS-1:0] data_in,
	input  logic                         wr,
	output logic [io_pkg::DATA_BITS-1:0] data_out,
	output logic                         audio_tick
);

	logic [io_pkg::DATA_BITS-1:0] divisor;
	logic [io_pkg::DATA_BITS-1:0] count;
	logic                         div_wr;

	assign div_wr = wr && (reg_addr == io_pkg::REG_AUDIO_DIVISOR);

	// divisor reads back as written
	assign data_out = (reg_addr == io_pkg::REG_AUDIO_DIVISOR) ? divisor : '0;

	// counts divisor down to zero, so one tick per divisor+1 cycles
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			divisor <= '0;
			count <= '0;
			audio_tick <= 1'b0;
		end else if (div_wr) begin
			// restart the period on a new divisor
			divisor <= data_in;
			count <= data_in;
			audio_tick <= 1'b0;
		end else if (divisor == '0) begin
			count <= '0;
			audio_tick <= 1'b0;
		end else if (count == '0) begin
			count <= divisor;
			audio_tick <= 1'b1;
		end else begin
			count <= count - 1'b1;
			audio_tick <= 1'b0;
		end
	end

endmodule

/* src/spi_flash_engine.sv */
// SPI flash byte engine, mode 0

module spi_flash_engine #(
	parameter int SPI_HALF = 4
) (
	input  logic                         CLK,
	input  logic                         RSTb,
	input  logic [io_pkg::REG_BITS-1:0]  reg_addr,
	input  logic [io_pkg::DATA_BITS-1:0] data_in,
	input  logic                         wr,
	input  logic                         spi_miso,
	output logic [io_pkg::DATA_BITS-1:0] data_out,
	output logic                         spi_sclk,
	output logic                         spi_mosi,
	output logic                         spi_cs_b,
	output logic                         spi_done
);

	localparam int HALF_BITS = $clog2(SPI_HALF + 1);
	localparam logic [HALF_BITS-1:0] HALF_LAST = HALF_BITS'(SPI_HALF - 1);

	logic                 busy;
	logic [HALF_BITS-1:0] half_count;
	logic [3:0]           edge_count;
	logic [7:0]           tx_shift;
	logic [7:0]           rx_shift;
	logic                 start;

	assign start = wr && !busy && (reg_addr == io_pkg::REG_SPI_DATA);
	assign spi_mosi = tx_shift[7];

	always_comb begin
		data_out = '0;
		case (reg_addr)
			io_pkg::REG_SPI_DATA:   data_out[7:0] = rx_shift;
			io_pkg::REG_SPI_STATUS: data_out[0] = busy;
			default: ;
		endcase
	end

	// ========================================
	// shift engine
	// ========================================
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			busy <= 1'b0;
			spi_cs_b <= 1'b1;
			spi_sclk <= 1'b0;
			spi_done <= 1'b0;
			half_count <= '0;
			edge_count <= 4'd0;
		end else begin
			spi_done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				spi_cs_b <= 1'b0;
				spi_sclk <= 1'b0;
				half_count <= '0;
				edge_count <= 4'd0;
			end else if (busy) begin
				if (half_count == HALF_LAST) begin
					half_count <= '0;
					edge_count <= edge_count + 1'b1;
					if (edge_count == 4'd15) begin
						// sixteenth half period, byte complete
						busy <= 1'b0;
						spi_cs_b <= 1'b1;
						spi_sclk <= 1'b0;
						spi_done <= 1'b1;
					end else begin
						spi_sclk <= ~spi_sclk;
					end
				end else begin
					half_count <= half_count + 1'b1;
				end
			end
		end
	end

	// byte registers, MISO taken on rising sclk, MOSI moved on falling
	always_ff @(posedge CLK) begin
		if (start) begin
			tx_shift <= data_in[7:0];
		end else if (busy && half_count == HALF_LAST) begin
			if (!spi_sclk) begin
				rx_shift <= {rx_shift[6:0], spi_miso};
			end else begin
				tx_shift <= {tx_shift[6:0], 1'b0};
			end
		end
	end

endmodule

/* src/io_subsystem.sv */
// I/O subsystem top level

module io_subsystem #(
	parameter int H_TOTAL  = 800,
	parameter int V_TOTAL  = 525,
	parameter int SPI_HALF = 4
) (
	input  logic                         CLK,
	input  logic                         RSTb,
	input  logic [io_pkg::ADDR_BITS-1:0] address,
	input  logic [io_pkg::DATA_BITS-1:0] data_in,
	input  logic                         wr,
	input  logic                         spi_miso,
	output logic [io_pkg::DATA_BITS-1:0] data_out,
	output logic                         hsync,
	output logic                         vsync,
	output logic                         spi_sclk,
	output logic                         spi_mosi,
	output logic                         spi_cs_b,
	output logic                         interrupt,
	output logic [3:0]                   irq
);

	logic [io_pkg::REG_BITS-1:0]  reg_addr;
	logic                         wr_irq;
	logic                         wr_video;
	logic                         wr_audio;
	logic                         wr_spi;
	logic [io_pkg::DATA_BITS-1:0] rd_irq;
	logic [io_pkg::DATA_BITS-1:0] rd_video;
	logic [io_pkg::DATA_BITS-1:0] rd_audio;
	logic [io_pkg::DATA_BITS-1:0] rd_spi;
	// event pulses into the controller
	logic                         audio_tick;
	logic                         spi_done;

	io_decoder u_decoder (
		.address(address), .wr(wr),
		.rd_irq(rd_irq), .rd_video(rd_video), .rd_audio(rd_audio), .rd_spi(rd_spi),
		.reg_addr(reg_addr),
		.wr_irq(wr_irq), .wr_video(wr_video), .wr_audio(wr_audio), .wr_spi(wr_spi),
		.data_out(data_out)
	);

	video_timing #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)) u_video (
		.CLK(CLK), .RSTb(RSTb), .reg_addr(reg_addr), .data_in(data_in), .wr(wr_video),
		.data_out(rd_video), .hsync(hsync), .vsync(vsync)
	);

	audio_sample_timer u_audio (
		.CLK(CLK), .RSTb(RSTb), .reg_addr(reg_addr), .data_in(data_in), .wr(wr_audio),
		.data_out(rd_audio), .audio_tick(audio_tick)
	);

	spi_flash_engine #(.SPI_HALF(SPI_HALF)) u_spi (
		.CLK(CLK), .RSTb(RSTb), .reg_addr(reg_addr), .data_in(data_in), .wr(wr_spi),
		.spi_miso(spi_miso), .data_out(rd_spi),
		.spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_cs_b(spi_cs_b),
		.spi_done(spi_done)
	);

	interrupt_controller u_irq (
		.CLK(CLK), .RSTb(RSTb), .reg_addr(reg_addr), .data_in(data_in), .wr(wr_irq),
		.irq_hsync(hsync), .irq_vsync(vsync),
		.irq_audio(audio_tick), .irq_spi_flash(spi_done),
		.data_out(rd_irq), .interrupt(interrupt), .irq(irq)
	);

endmodule

/* tb/io_subsystem_properties.sv */
// Bound assertions for the I/O subsystem

module io_subsystem_properties #(
	parameter int H_TOTAL = 800,
	parameter int V_TOTAL = 525
) (
	input logic                         CLK,
	input logic                         RSTb,
	input logic                         hsync,
	input logic                         vsync,
	input logic                         audio_tick,
	input logic                         spi_done,
	input logic                         spi_busy,
	input logic                         video_enable,
	input logic [io_pkg::DATA_BITS-1:0] divisor,
	input logic [io_pkg::NUM_IRQ-1:0]   pending,
	input logic [io_pkg::NUM_IRQ-1:0]   enabled,
	input logic                         interrupt,
	input logic [3:0]                   irq
);

	int                           failures = 0;
	int                           tick_gap;
	int                           h_gap;
	int                           v_gap;
	logic                         tick_seen;
	logic                         h_seen;
	logic                         v_seen;
	logic [io_pkg::DATA_BITS-1:0] divisor_q;
	logic [io_pkg::NUM_IRQ-1:0]   active;

	assign active = pending & enabled;

	// request code for a pending-and-enabled vector, 0 when none
	function automatic logic [3:0] lowest_code(input logic [io_pkg::NUM_IRQ-1:0] v);
		logic [io_pkg::NUM_IRQ-1:0] low_bit;
		if (v == '0) begin
			return 4'd0;
		end
		// isolate the lowest set bit, then take its position
		low_bit = v & (~v + 1'b1);
		return 4'($clog2(low_bit)) + 4'd1;
	endfunction

	// ========================================
	// pulse spacing counters
	// ========================================
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			tick_gap <= 0;
			h_gap <= 0;
			v_gap <= 0;
			tick_seen <= 1'b0;
			h_seen <= 1'b0;
			v_seen <= 1'b0;
			divisor_q <= '0;
		end else begin
			divisor_q <= divisor;
			tick_gap <= audio_tick ? 1 : tick_gap + 1;
			h_gap <= hsync ? 1 : h_gap + 1;
			v_gap <= vsync ? 1 : v_gap + 1;
			// a new divisor restarts the audio period
			tick_seen <= audio_tick || (tick_seen && divisor == divisor_q);
			h_seen <= video_enable && (hsync || h_seen);
			v_seen <= video_enable && (vsync || v_seen);
		end
	end

	// ========================================
	// assertions
	// ========================================
	a_reset: assert property (@(posedge CLK)
		!RSTb |=> (!interrupt && irq == 4'd0 && pending == '0 && enabled == '0))
		else begin
			$error("interrupt state not cleared by reset");
			failures++;
		end

	a_priority: assert property (@(posedge CLK) disable iff (!RSTb)
		1'b1 |=> (irq == lowest_code($past(active)) && interrupt == (irq != 4'd0)))
		else begin
			$error("irq %0d does not match pending-and-enabled", irq);
			failures++;
		end

	a_audio_period: assert property (@(posedge CLK) disable iff (!RSTb)
		(audio_tick && tick_seen) |-> tick_gap == int'(divisor) + 1)
		else begin
			$error("audio tick after %0d cycles with divisor %0d", tick_gap, divisor);
			failures++;
		end

	a_hsync_period: assert property (@(posedge CLK) disable iff (!RSTb)
		(hsync && h_seen) |-> h_gap == H_TOTAL)
		else begin
			$error("hsync after %0d cycles", h_gap);
			failures++;
		end

	a_vsync_period: assert property (@(posedge CLK) disable iff (!RSTb)
		(vsync && v_seen) |-> v_gap == H_TOTAL * V_TOTAL)
		else begin
			$error("vsync after %0d cycles", v_gap);
			failures++;
		end

	// done pulses exactly on the cycle busy falls
	a_spi_done: assert property (@(posedge CLK) disable iff (!RSTb)
		spi_done == $fell(spi_busy))
		else begin
			$error("spi_done out of step with busy");
			failures++;
		end

endmodule

bind io_subsystem io_subsystem_properties #(
	.H_TOTAL(H_TOTAL),
	.V_TOTAL(V_TOTAL)
) props (
	.CLK(CLK), .RSTb(RSTb), .hsync(hsync), .vsync(vsync),
	.audio_tick(audio_tick), .spi_done(spi_done), .spi_busy(u_spi.busy),
	.video_enable(u_video.enable), .divisor(u_audio.divisor),
	.pending(u_irq.irq_pending), .enabled(u_irq.irq_enabled),
	.interrupt(interrupt), .irq(irq)
);

/* tb/io_subsystem_tb.sv */
// I/O subsystem testbench

module io_subsystem_tb;

	localparam logic [7:0] IRQ_ENABLE    = {io_pkg::DEV_IRQ, io_pkg::REG_IRQ_ENABLE};
	localparam logic [7:0] IRQ_PENDING   = {io_pkg::DEV_IRQ, io_pkg::REG_IRQ_PENDING};
	localparam logic [7:0] VIDEO_ENABLE  = {io_pkg::DEV_VIDEO, io_pkg::REG_VIDEO_ENABLE};
	localparam logic [7:0] AUDIO_DIVISOR = {io_pkg::DEV_AUDIO, io_pkg::REG_AUDIO_DIVISOR};
	localparam logic [7:0] SPI_DATA      = {io_pkg::DEV_SPI, io_pkg::REG_SPI_DATA};
	localparam logic [7:0] SPI_STATUS    = {io_pkg::DEV_SPI, io_pkg::REG_SPI_STATUS};

	logic        CLK;
	logic        RSTb;
	logic [7:0]  address;
	logic [15:0] data_in;
	logic        wr;
	logic [15:0] data_out;
	logic        hsync;
	logic        vsync;
	logic        spi_sclk;
	logic        spi_mosi;
	logic        spi_cs_b;
	logic        interrupt;
	logic [3:0]  irq;

	string test_name;
	int    errors = 0;
	int    mark = 0;
	int    tests_run = 0;
	int    failed_tests = 0;
	int    vsync_count = 0;
	int    tick_count = 0;
	int    sclk_rises = 0;

	// MISO looped back to MOSI
	io_subsystem #(.H_TOTAL(20), .V_TOTAL(4), .SPI_HALF(2)) uut (
		.CLK(CLK), .RSTb(RSTb), .address(address), .data_in(data_in), .wr(wr),
		.spi_miso(spi_mosi), .data_out(data_out), .hsync(hsync), .vsync(vsync),
		.spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_cs_b(spi_cs_b),
		.interrupt(interrupt), .irq(irq)
	);

	always #50 CLK = ~CLK;

	always @(posedge CLK) begin
		if (vsync) begin
			vsync_count++;
		end
		if (uut.audio_tick) begin
			tick_count++;
		end
	end

	// count rising sclk edges
	always @(posedge spi_sclk) begin
		sclk_rises++;
	end

	// ========================================
	// bus tasks
	// ========================================
	task automatic write_reg(input logic [7:0] addr, input logic [15:0] value);
		@(posedge CLK);
		#10;
		address = addr;
		data_in = value;
		wr = 1'b1;
		@(posedge CLK);
		#10;
		wr = 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [15:0] value);
		@(posedge CLK);
		#10;
		address = addr;
		wr = 1'b0;
		// combinational read settles by mid cycle
		@(negedge CLK);
		value = data_out;
	endtask

	task automatic compare_value(input string what, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED: %s %s expected %h actual %h",
				test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic check_read(input string what, input logic [7:0] addr,
		input logic [15:0] expected);
		logic [15:0] value;
		read_reg(addr, value);
		compare_value(what, expected, value);
	endtask

	task automatic close_test();
		int failed;
		failed = errors + uut.props.failures - mark;
		$display("test %s: %s", test_name, (failed == 0) ? "ok" : "failed");
		tests_run++;
		if (failed != 0) begin
			failed_tests++;
		end
		mark = errors + uut.props.failures;
	endtask

	initial begin
		logic [15:0] value;
		logic [15:0] divisor;
		logic [7:0]  byte_out;
		int          polls;
		int          v_start;
		int          t_start;
		int          rise_start;
		void'($urandom(32'hfe36_1015));
		CLK = 1'b0;
		RSTb = 1'b0;
		address = '0;
		data_in = '0;
		wr = 1'b0;
		repeat (3) @(posedge CLK);
		#10;
		RSTb = 1'b1;

		test_name = "reset";
		@(negedge CLK);
		compare_value("interrupt", 16'h0000, 16'(interrupt));
		compare_value("irq", 16'h0000, 16'(irq));
		compare_value("spi_cs_b", 16'h0001, 16'(spi_cs_b));
		compare_value("spi_sclk", 16'h0000, 16'(spi_sclk));
		check_read("enable", IRQ_ENABLE, 16'h0000);
		check_read("pending", IRQ_PENDING, 16'h0000);
		close_test();

		// random enable masks while all four sources run
		test_name = "priority";
		divisor = 16'($urandom_range(15, 1));
		write_reg(AUDIO_DIVISOR, divisor);
		write_reg(VIDEO_ENABLE, 16'h0001);
		write_reg(SPI_DATA, 16'($urandom_range(255)));
		repeat (16) begin
			value = 16'($urandom_range(15));
			write_reg(IRQ_ENABLE, value);
			check_read("enable", IRQ_ENABLE, value);
			write_reg(IRQ_PENDING, 16'($urandom_range(15)));
			repeat ($urandom_range(12, 2)) @(posedge CLK);
		end
		close_test();

		test_name = "timers";
		check_read("divisor", AUDIO_DIVISOR, divisor);
		v_start = vsync_count;
		t_start = tick_count;
		polls = 0;
		while ((vsync_count - v_start < 3 || tick_count - t_start < 3) && polls < 1000) begin
			@(posedge CLK);
			polls++;
		end
		if (vsync_count - v_start < 3 || tick_count - t_start < 3) begin
			$display("timeout: vsync or audio pulses stopped in test %s", test_name);
			errors++;
		end
		close_test();

		// ========================================
		// pending and clear with video off
		// ========================================
		test_name = "pending";
		write_reg(VIDEO_ENABLE, 16'h0000);
		write_reg(AUDIO_DIVISOR, 16'h0000);
		write_reg(IRQ_PENDING, 16'h000f);
		check_read("cleared", IRQ_PENDING, 16'h0000);
		write_reg(AUDIO_DIVISOR, 16'($urandom_range(9, 2)));
		polls = 0;
		do begin
			read_reg(IRQ_PENDING, value);
			polls++;
		end while (!value[io_pkg::IRQ_AUDIO] && polls < 64);
		if (!value[io_pkg::IRQ_AUDIO]) begin
			$display("timeout: audio tick never set its pending bit");
			errors++;
		end
		compare_value("after tick", 16'h0004, value);
		write_reg(AUDIO_DIVISOR, 16'h0000);
		write_reg(IRQ_PENDING, 16'h0004);
		check_read("after clear", IRQ_PENDING, 16'h0000);
		close_test();

		test_name = "spi loopback";
		byte_out = 8'($urandom_range(255));
		rise_start = sclk_rises;
		write_reg(SPI_DATA, {8'h00, byte_out});
		check_read("busy", SPI_STATUS, 16'h0001);
		compare_value("spi_cs_b busy", 16'h0000, 16'(spi_cs_b));
		polls = 0;
		do begin
			read_reg(SPI_STATUS, value);
			polls++;
		end while (value[0] && polls < 100);
		if (value[0]) begin
			$display("timeout: SPI engine stayed busy");
			errors++;
		end
		compare_value("spi_cs_b idle", 16'h0001, 16'(spi_cs_b));
		compare_value("spi_sclk idle", 16'h0000, 16'(spi_sclk));
		compare_value("sclk rises", 16'd8, 16'(sclk_rises - rise_start));
		check_read("data", SPI_DATA, {8'h00, byte_out});
		check_read("pending", IRQ_PENDING, 16'h0008);
		close_test();

		$display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
			tests_run, failed_tests, errors, uut.props.failures);
		if (errors == 0 && uut.props.failures == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* src.f */
src/io_pkg.sv
src/interrupt_controller.sv
src/io_decoder.sv
src/video_timing.sv
src/audio_sample_timer.sv
src/spi_flash_engine.sv
src/io_subsystem.sv
tb/io_subsystem_properties.sv
tb/io_subsystem_tb.sv
